// ==== isa_pkg.sv ====
// RV32I opcodes, funct3 codes, instruction field layouts and immediate type
package isa_pkg;

    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;
    typedef logic [31:0] imm_t;

    // Major opcodes
    localparam opcode_t LOAD   = 7'b0000011;
    localparam opcode_t OP_IMM = 7'b0010011;
    localparam opcode_t AUIPC  = 7'b0010111;
    localparam opcode_t STORE  = 7'b0100011;
    localparam opcode_t OP     = 7'b0110011;
    localparam opcode_t LUI    = 7'b0110111;
    localparam opcode_t BRANCH = 7'b1100011;
    localparam opcode_t JALR   = 7'b1100111;
    localparam opcode_t JAL    = 7'b1101111;

    // funct3 codes shared across branch, load, store and ALU groups
    localparam funct3_t BEQ_LB_SB_ADD_SUB = 3'b000;
    localparam funct3_t BNE_LH_SH_SLL     = 3'b001;
    localparam funct3_t LW_SW_SLT         = 3'b010;
    localparam funct3_t SLTU_SLTIU        = 3'b011;
    localparam funct3_t BLT_LBU_XOR       = 3'b100;
    localparam funct3_t BGE_LHU_SRL_SRA   = 3'b101;
    localparam funct3_t BLTU_OR           = 3'b110;
    localparam funct3_t BGEU_AND          = 3'b111;

    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            funct3_t    funct3;
            logic [4:0] rd;
            opcode_t    opcode;
        } r;
        struct packed {
            logic [11:0] imm_11_0;
            logic [4:0]  rs1;
            funct3_t     funct3;
            logic [4:0]  rd;
            opcode_t     opcode;
        } i;
        struct packed {
            logic [6:0] imm_11_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            funct3_t    funct3;
            logic [4:0] imm_4_0;
            opcode_t    opcode;
        } s;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            funct3_t    funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            opcode_t    opcode;
        } sb;
        struct packed {
            logic [19:0] imm_31_12;
            logic [4:0]  rd;
            opcode_t     opcode;
        } u;
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            logic [4:0] rd;
            opcode_t    opcode;
        } uj;
    } inst_t;

endpackage

// ==== core_pkg.sv ====
// Pipeline word types, control record, forwarding select and stage payload records
package core_pkg;

    localparam int NUM_REGS = 32;

    typedef logic [31:0] word_t;
    typedef logic [4:0] addr_t;

    // Result kind seen at the output stage
    typedef enum logic [3:0] {
        NULL, REGISTER, LOAD_WORD, LOAD_HALF, LOAD_HALF_UNSIGNED,
        LOAD_BYTE, LOAD_BYTE_UNSIGNED, STORE_WORD, STORE_HALF, STORE_BYTE
    } op_t;

    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, OP2, ANY
    } fun_t;

    typedef enum logic [2:0] {
        NONE, JAL_OR_JALR, BEQ, BNE, BLT, BGE, BLTU, BGEU
    } jmp_t;

    typedef enum logic {RS1, PC} op1_t;
    typedef enum logic [2:0] {RS2, I_IMM, S_IMM, B_IMM, U_IMM, J_IMM} op2_t;

    // Operand source for forwarding
    typedef enum logic [1:0] {REG, ALU, EXE} rs_t;

    typedef struct packed {
        op_t  op;
        fun_t fun;
        jmp_t jmp;
        op1_t op1;
        op2_t op2;
    } ctrl_t;

    // Control word of an undecodable instruction
    localparam ctrl_t CTRL_KILL = '{NULL, ANY, NONE, RS1, RS2};

    typedef struct packed {
        word_t          pc;
        isa_pkg::inst_t ir;
    } id_t;

    typedef struct packed {
        ctrl_t ctrl;
        word_t pc;
        word_t op1;
        word_t op2;
        word_t rs1;
        word_t rs2;
        addr_t rd;
    } ex_t;

    typedef struct packed {
        op_t   op;
        addr_t rd;
        word_t result;
        word_t store;
        logic  taken;
        word_t target;
    } wb_t;

endpackage

// ==== pipe_reg.sv ====
// Valid/ready pipeline stage register with a type-parameterised payload
`timescale 1ns/1ns

module pipe_reg #(
    parameter type T = logic
) (
    input  logic down,
    input  logic arst_n,
    input  logic advance,
    input  logic in_valid,
    input  T     in_data,
    output logic out_valid,
    output T     out_data
);

    always_ff @(posedge down or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
        end else if (advance) begin
            out_valid <= in_valid;
        end
    end

    // Payload only moves with the stage
    always_ff @(posedge down) begin
        if (advance) begin
            out_data <= in_data;
        end
    end

endmodule

// ==== regfile.sv ====
// Integer register file with two asynchronous reads and one synchronous write
`timescale 1ns/1ns

module regfile
    import core_pkg::*;
(
    input  logic  down,
    input  logic  arst_n,
    input  addr_t rs1_addr,
    input  addr_t rs2_addr,
    output word_t rs1_data,
    output word_t rs2_data,
    input  logic  we,
    input  addr_t rd,
    input  word_t wd
);

    word_t regs [NUM_REGS];

    always_ff @(posedge down or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wd;
        end
    end

    // x0 is hard zero
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// ==== decode.sv ====
// Instruction decoder, immediates, operand forwarding and execute stage register
`timescale 1ns/1ns

module decode
    import isa_pkg::*;
    import core_pkg::*;
(
    input  logic  down,
    input  logic  arst_n,
    input  logic  advance,
    input  logic  in_valid,
    input  id_t   in_data,
    input  rs_t   rs1_sel,
    input  rs_t   rs2_sel,
    input  word_t alu_data,
    input  word_t exe_data,
    input  word_t rs1_data,
    input  word_t rs2_data,
    output addr_t rs1_addr,
    output addr_t rs2_addr,
    output logic  illegal,
    output logic  ex_valid,
    output ex_t   ex_data
);

    word_t pc;
    inst_t ir;
    ctrl_t ctrl;
    fun_t  fun;
    imm_t  i_imm;
    imm_t  s_imm;
    imm_t  b_imm;
    imm_t  u_imm;
    imm_t  j_imm;
    word_t rs1;
    word_t rs2;
    word_t op1;
    word_t op2;
    op_t   ex_op;
    ex_t   ex_q;

    function automatic word_t forward(rs_t sel, word_t reg_data, word_t alu, word_t exe);
        case (sel)
            ALU:     return alu;
            EXE:     return exe;
            default: return reg_data;
        endcase
    endfunction

    assign pc = in_data.pc;
    assign ir = in_data.ir;
    assign rs1_addr = ir.r.rs1;
    assign rs2_addr = ir.r.rs2;

    assign i_imm = imm_t'({{20{ir.i.imm_11_0[11]}}, ir.i.imm_11_0});
    assign s_imm = imm_t'({{20{ir.s.imm_11_5[6]}}, ir.s.imm_11_5, ir.s.imm_4_0});
    assign b_imm = imm_t'({{20{ir.sb.imm_12}}, ir.sb.imm_11, ir.sb.imm_10_5, ir.sb.imm_4_1, 1'b0});
    assign u_imm = imm_t'({ir.u.imm_31_12, 12'd0});
    assign j_imm = imm_t'({{12{ir.uj.imm_20}}, ir.uj.imm_19_12, ir.uj.imm_11,
                           ir.uj.imm_10_1, 1'b0});

    // ALU function for OP and OP-IMM, bit 30 gives SUB only on OP
    always_comb begin
        unique case (ir.r.funct3)
            BEQ_LB_SB_ADD_SUB: fun = (ir.r.opcode == OP && ir.r.funct7[5]) ? SUB : ADD;
            BNE_LH_SH_SLL:     fun = SLL;
            LW_SW_SLT:         fun = SLT;
            SLTU_SLTIU:        fun = SLTU;
            BLT_LBU_XOR:       fun = XOR;
            BGE_LHU_SRL_SRA:   fun = ir.r.funct7[5] ? SRA : SRL;
            BLTU_OR:           fun = OR;
            default:           fun = AND;
        endcase
    end

    always_comb begin
        unique case (ir.r.opcode)
            OP_IMM: ctrl = '{REGISTER, fun, NONE, RS1, I_IMM};
            OP:     ctrl = '{REGISTER, fun, NONE, RS1, RS2};
            LUI:    ctrl = '{REGISTER, OP2, NONE, RS1, U_IMM};
            AUIPC:  ctrl = '{REGISTER, ADD, NONE, PC, U_IMM};
            JAL:    ctrl = '{REGISTER, ADD, JAL_OR_JALR, PC, J_IMM};
            JALR:   ctrl = '{REGISTER, ADD, JAL_OR_JALR, RS1, I_IMM};
            BRANCH: begin
                unique case (ir.r.funct3)
                    BEQ_LB_SB_ADD_SUB: ctrl = '{NULL, ADD, BEQ, PC, B_IMM};
                    BNE_LH_SH_SLL:     ctrl = '{NULL, ADD, BNE, PC, B_IMM};
                    BLT_LBU_XOR:       ctrl = '{NULL, ADD, BLT, PC, B_IMM};
                    BGE_LHU_SRL_SRA:   ctrl = '{NULL, ADD, BGE, PC, B_IMM};
                    BLTU_OR:           ctrl = '{NULL, ADD, BLTU, PC, B_IMM};
                    BGEU_AND:          ctrl = '{NULL, ADD, BGEU, PC, B_IMM};
                    default:           ctrl = CTRL_KILL;
                endcase
            end
            LOAD: begin
                unique case (ir.r.funct3)
                    BEQ_LB_SB_ADD_SUB: ctrl = '{LOAD_BYTE, ADD, NONE, RS1, I_IMM};
                    BNE_LH_SH_SLL:     ctrl = '{LOAD_HALF, ADD, NONE, RS1, I_IMM};
                    LW_SW_SLT:         ctrl = '{LOAD_WORD, ADD, NONE, RS1, I_IMM};
                    BLT_LBU_XOR:       ctrl = '{LOAD_BYTE_UNSIGNED, ADD, NONE, RS1, I_IMM};
                    BGE_LHU_SRL_SRA:   ctrl = '{LOAD_HALF_UNSIGNED, ADD, NONE, RS1, I_IMM};
                    default:           ctrl = CTRL_KILL;
                endcase
            end
            STORE: begin
                unique case (ir.r.funct3)
                    BEQ_LB_SB_ADD_SUB: ctrl = '{STORE_BYTE, ADD, NONE, RS1, S_IMM};
                    BNE_LH_SH_SLL:     ctrl = '{STORE_HALF, ADD, NONE, RS1, S_IMM};
                    LW_SW_SLT:         ctrl = '{STORE_WORD, ADD, NONE, RS1, S_IMM};
                    default:           ctrl = CTRL_KILL;
                endcase
            end
            default: ctrl = CTRL_KILL;
        endcase
    end

    assign rs1 = forward(rs1_sel, rs1_data, alu_data, exe_data);
    assign rs2 = forward(rs2_sel, rs2_data, alu_data, exe_data);

    assign op1 = (ctrl.op1 == PC) ? pc : rs1;

    always_comb begin
        case (ctrl.op2)
            I_IMM:   op2 = i_imm;
            S_IMM:   op2 = s_imm;
            B_IMM:   op2 = b_imm;
            U_IMM:   op2 = u_imm;
            J_IMM:   op2 = j_imm;
            default: op2 = rs2;
        endcase
    end

    always_ff @(posedge down or negedge arst_n) begin
        if (!arst_n) begin
            ex_valid <= 1'b0;
            ex_op    <= NULL;
        end else if (advance) begin
            ex_valid <= in_valid;
            ex_op    <= ctrl.op;
        end
    end

    always_ff @(posedge down) begin
        if (advance) begin
            ex_q <= '{ctrl, pc, op1, op2, rs1, rs2, ir.r.rd};
        end
    end

    // Kind comes from the reset flop
    always_comb begin
        ex_data = ex_q;
        ex_data.ctrl.op = ex_op;
    end

    assign illegal = in_valid && (ctrl == CTRL_KILL);

endmodule

// ==== execute.sv ====
// ALU, branch comparison and target, and the result record for the output stage
`timescale 1ns/1ns

module execute
    import core_pkg::*;
(
    input  logic  ex_valid,
    input  ex_t   ex_data,
    output word_t alu_data,
    output wb_t   res,
    output logic  writes
);

    word_t op1;
    word_t op2;
    word_t alu;
    word_t link;
    logic  cmp;

    assign op1  = ex_data.op1;
    assign op2  = ex_data.op2;
    assign link = ex_data.pc + 32'd4;

    always_comb begin
        case (ex_data.ctrl.fun)
            ADD:     alu = op1 + op2;
            SUB:     alu = op1 - op2;
            SLL:     alu = op1 << op2[4:0];
            SLT:     alu = word_t'($signed(op1) < $signed(op2));
            SLTU:    alu = word_t'(op1 < op2);
            XOR:     alu = op1 ^ op2;
            SRL:     alu = op1 >> op2[4:0];
            SRA:     alu = word_t'($signed(op1) >>> op2[4:0]);
            OR:      alu = op1 | op2;
            AND:     alu = op1 & op2;
            OP2:     alu = op2;
            default: alu = '0;
        endcase
    end

    // Branch condition on the forwarded source values
    always_comb begin
        case (ex_data.ctrl.jmp)
            JAL_OR_JALR: cmp = 1'b1;
            BEQ:         cmp = ex_data.rs1 == ex_data.rs2;
            BNE:         cmp = ex_data.rs1 != ex_data.rs2;
            BLT:         cmp = $signed(ex_data.rs1) < $signed(ex_data.rs2);
            BGE:         cmp = $signed(ex_data.rs1) >= $signed(ex_data.rs2);
            BLTU:        cmp = ex_data.rs1 < ex_data.rs2;
            BGEU:        cmp = ex_data.rs1 >= ex_data.rs2;
            default:     cmp = 1'b0;
        endcase
    end

    always_comb begin
        res.op     = ex_data.ctrl.op;
        res.rd     = ex_data.rd;
        res.taken  = cmp;
        res.result = alu;
        res.store  = '0;
        res.target = '0;
        if (ex_data.ctrl.jmp == JAL_OR_JALR) begin
            res.result = link;
        end
        // JALR drops bit 0 of the target
        if (ex_data.ctrl.jmp != NONE) begin
            res.target = {alu[31:1], alu[0] & (ex_data.ctrl.op1 == PC)};
        end
        if (ex_data.ctrl.op != NULL && ex_data.ctrl.op != REGISTER) begin
            res.store = ex_data.rs2;
        end
    end

    assign alu_data = res.result;
    assign writes   = ex_valid && ex_data.ctrl.op == REGISTER && ex_data.rd != '0;

endmodule

// ==== hazard_ctrl.sv ====
// Forwarding selection for both sources and the common pipeline advance enable
`timescale 1ns/1ns

module hazard_ctrl
    import core_pkg::*;
(
    input  logic  res_ready,
    input  logic  out_valid,
    input  addr_t rs1_addr,
    input  addr_t rs2_addr,
    input  addr_t ex_rd,
    input  logic  ex_writes,
    input  addr_t out_rd,
    input  logic  out_writes,
    output rs_t   rs1_sel,
    output rs_t   rs2_sel,
    output logic  advance
);

    // Youngest producer wins
    function automatic rs_t pick(addr_t rs, logic ex_w, addr_t ex_d, logic out_w, addr_t out_d);
        if (ex_w && ex_d == rs) begin
            return ALU;
        end
        if (out_w && out_d == rs) begin
            return EXE;
        end
        return REG;
    endfunction

    assign rs1_sel = pick(rs1_addr, ex_writes, ex_rd, out_writes, out_rd);
    assign rs2_sel = pick(rs2_addr, ex_writes, ex_rd, out_writes, out_rd);

    assign advance = !out_valid || res_ready;

endmodule

// ==== rv_core_top.sv ====
// RV32I pipeline slice: input, decode, execute and output stages with register file
`timescale 1ns/1ns

module rv_core_top
    import core_pkg::*;
(
    input  logic  down,
    input  logic  arst_n,
    input  logic  inst_valid,
    output logic  inst_ready,
    input  word_t inst_pc,
    input  word_t inst_ir,
    output logic  res_valid,
    input  logic  res_ready,
    output op_t   res_op,
    output addr_t res_rd,
    output word_t res_value,
    output word_t res_store,
    output logic  res_taken,
    output word_t res_target,
    output logic  illegal
);

    logic  advance;
    logic  id_valid;
    id_t   id_data;
    logic  ex_valid;
    ex_t   ex_data;
    word_t alu_data;
    wb_t   wb_data;
    logic  ex_writes;
    wb_t   out_data;
    logic  out_writes;
    addr_t rs1_addr;
    addr_t rs2_addr;
    word_t rs1_data;
    word_t rs2_data;
    rs_t   rs1_sel;
    rs_t   rs2_sel;

    pipe_reg #(.T(id_t)) u_in (
        .down      (down),
        .arst_n    (arst_n),
        .advance   (advance),
        .in_valid  (inst_valid),
        .in_data   ({inst_pc, inst_ir}),
        .out_valid (id_valid),
        .out_data  (id_data)
    );

    decode u_decode (
        .down     (down),
        .arst_n   (arst_n),
        .advance  (advance),
        .in_valid (id_valid),
        .in_data  (id_data),
        .rs1_sel  (rs1_sel),
        .rs2_sel  (rs2_sel),
        .alu_data (alu_data),
        .exe_data (out_data.result),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .illegal  (illegal),
        .ex_valid (ex_valid),
        .ex_data  (ex_data)
    );

    execute u_execute (
        .ex_valid (ex_valid),
        .ex_data  (ex_data),
        .alu_data (alu_data),
        .res      (wb_data),
        .writes   (ex_writes)
    );

    pipe_reg #(.T(wb_t)) u_out (
        .down      (down),
        .arst_n    (arst_n),
        .advance   (advance),
        .in_valid  (ex_valid),
        .in_data   (wb_data),
        .out_valid (res_valid),
        .out_data  (out_data)
    );

    // Writeback happens as the result leaves
    regfile u_regfile (
        .down     (down),
        .arst_n   (arst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (out_writes && res_ready),
        .rd       (out_data.rd),
        .wd       (out_data.result)
    );

    hazard_ctrl u_hazard (
        .res_ready  (res_ready),
        .out_valid  (res_valid),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .ex_rd      (ex_data.rd),
        .ex_writes  (ex_writes),
        .out_rd     (out_data.rd),
        .out_writes (out_writes),
        .rs1_sel    (rs1_sel),
        .rs2_sel    (rs2_sel),
        .advance    (advance)
    );

    assign out_writes = res_valid && out_data.op == REGISTER && out_data.rd != '0;

    assign inst_ready = advance;
    assign res_op     = out_data.op;
    assign res_rd     = out_data.rd;
    assign res_value  = out_data.result;
    assign res_store  = out_data.store;
    assign res_taken  = out_data.taken;
    assign res_target = out_data.target;

endmodule

// ==== rv_core_properties.sv ====
// Bound assertions on the instruction and result stream handshakes and on x0 operands
`timescale 1ns/1ns

module rv_core_properties
    import core_pkg::*;
(
    input logic  down,
    input logic  arst_n,
    input logic  inst_valid,
    input logic  inst_ready,
    input word_t inst_pc,
    input word_t inst_ir,
    input logic  res_valid,
    input logic  res_ready,
    input op_t   res_op,
    input addr_t res_rd,
    input word_t res_value,
    input word_t res_store,
    input logic  res_taken,
    input word_t res_target,
    input logic  advance,
    input addr_t rs1_addr,
    input addr_t rs2_addr,
    input ex_t   ex_data
);

    int failures = 0;

    inst_hold: assert property (@(posedge down) disable iff (!arst_n)
        inst_valid && !inst_ready |=> inst_valid && $stable({inst_pc, inst_ir}))
    else begin
        $error("Instruction dropped or changed before its transfer");
        failures++;
    end

    // Output register frozen while stalled
    res_hold: assert property (@(posedge down) disable iff (!arst_n)
        res_valid && !res_ready |=> res_valid
            && $stable({res_op, res_rd, res_value, res_store, res_taken, res_target}))
    else begin
        $error("Result dropped or changed while stalled");
        failures++;
    end

    // An x0 source enters execute as zero whatever is in flight
    x0_operand: assert property (@(posedge down) disable iff (!arst_n)
        (advance && rs1_addr == '0 |=> ex_data.rs1 == '0)
        and (advance && rs2_addr == '0 |=> ex_data.rs2 == '0))
    else begin
        $error("Operand read from x0 reached execute nonzero");
        failures++;
    end

endmodule

bind rv_core_top rv_core_properties u_props (.*);

// ==== tb_rv_core.sv ====
// Testbench for the RV32I pipeline slice: stimulus, reference model, scoreboard, watchdog
`timescale 1ns/1ns

module tb_rv_core
    import isa_pkg::*;
    import core_pkg::*;
();

    localparam int PERIOD   = 40;
    localparam int NUM_INST = 400;

    logic  down;
    logic  arst_n;
    logic  inst_valid;
    logic  inst_ready;
    word_t inst_pc;
    word_t inst_ir;
    logic  res_valid;
    logic  res_ready;
    op_t   res_op;
    addr_t res_rd;
    word_t res_value;
    word_t res_store;
    logic  res_taken;
    word_t res_target;
    logic  illegal;

    integer seed = 32'he854_597c;
    id_t    issued [$];
    word_t  shadow [NUM_REGS];

    rv_core_top dut (.*);

    task automatic abort_run(string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0t ns: %s is %h, expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_op(string name, op_t got, op_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0t ns: %s is %s, expected %s",
                                $time, name, got.name(), exp.name()));
        end
    endtask

    task automatic check_addr(string name, addr_t got, addr_t exp);
        if (got !== exp) begin
            abort_run($sformatf("Fail at %0t ns: %s is %0d, expected %0d", $time, name, got, exp));
        end
    endtask

    function automatic logic decodable(word_t ir);
        case (ir[6:0])
            OP_IMM, OP, LUI, AUIPC, JAL, JALR: return 1'b1;
            BRANCH:  return ir[14:12] != 3'd2 && ir[14:12] != 3'd3;
            LOAD:    return ir[14:12] != 3'd3 && ir[14:12] < 3'd6;
            STORE:   return ir[14:12] < 3'd3;
            default: return 1'b0;
        endcase
    endfunction

    function automatic word_t alu_ref(logic [2:0] f3, logic alt, word_t a, word_t b);
        case (f3)
            3'd0:    return alt ? a - b : a + b;
            3'd1:    return a << b[4:0];
            3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    return (a < b) ? 32'd1 : 32'd0;
            3'd4:    return a ^ b;
            3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_ref(logic [2:0] f3, word_t a, word_t b);
        case (f3)
            3'd0:    return a == b;
            3'd1:    return a != b;
            3'd4:    return $signed(a) < $signed(b);
            3'd5:    return $signed(a) >= $signed(b);
            3'd6:    return a < b;
            default: return a >= b;
        endcase
    endfunction

    // Expected result of one instruction executed in program order
    function automatic wb_t reference(word_t regs [NUM_REGS], word_t pc, word_t ir);
        wb_t        e;
        word_t      a;
        word_t      b;
        word_t      imm_i;
        word_t      imm_s;
        word_t      imm_b;
        word_t      imm_u;
        word_t      imm_j;
        logic [2:0] f3;
        logic       alt;
        f3    = ir[14:12];
        a     = regs[ir[19:15]];
        b     = regs[ir[24:20]];
        imm_i = {{20{ir[31]}}, ir[31:20]};
        imm_s = {{20{ir[31]}}, ir[31:25], ir[11:7]};
        imm_b = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
        imm_u = {ir[31:12], 12'd0};
        imm_j = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
        alt   = ir[30] && (ir[6:0] == OP || f3 == 3'd5);
        e     = '{op: NULL, rd: ir[11:7], result: '0, store: '0, taken: 1'b0, target: '0};
        if (!decodable(ir)) begin
            return e;
        end
        case (ir[6:0])
            OP_IMM: begin
                e.op     = REGISTER;
                e.result = alu_ref(f3, alt, a, imm_i);
            end
            OP: begin
                e.op     = REGISTER;
                e.result = alu_ref(f3, alt, a, b);
            end
            LUI: begin
                e.op     = REGISTER;
                e.result = imm_u;
            end
            AUIPC: begin
                e.op     = REGISTER;
                e.result = pc + imm_u;
            end
            JAL, JALR: begin
                e.op     = REGISTER;
                e.result = pc + 32'd4;
                e.taken  = 1'b1;
                e.target = (ir[6:0] == JAL) ? pc + imm_j : (a + imm_i) & ~32'd1;
            end
            BRANCH: begin
                e.result = pc + imm_b;
                e.target = pc + imm_b;
                e.taken  = branch_ref(f3, a, b);
            end
            LOAD: begin
                case (f3)
                    3'd0:    e.op = LOAD_BYTE;
                    3'd1:    e.op = LOAD_HALF;
                    3'd2:    e.op = LOAD_WORD;
                    3'd4:    e.op = LOAD_BYTE_UNSIGNED;
                    default: e.op = LOAD_HALF_UNSIGNED;
                endcase
                e.result = a + imm_i;
                e.store  = b;
            end
            default: begin
                case (f3)
                    3'd0:    e.op = STORE_BYTE;
                    3'd1:    e.op = STORE_HALF;
                    default: e.op = STORE_WORD;
                endcase
                e.result = a + imm_s;
                e.store  = b;
            end
        endcase
        return e;
    endfunction

    // Registers limited to x0..x7 so dependencies are frequent
    function automatic word_t make_inst();
        word_t ir;
        int    pick;
        ir        = $random(seed);
        pick      = $random(seed) & 15;
        ir[11:10] = 2'b00;
        ir[19:18] = 2'b00;
        ir[24:23] = 2'b00;
        case (pick)
            0, 1, 2, 3: begin
                ir[6:0] = OP_IMM;
                if (ir[13:12] == 2'b01) begin
                    ir[31:25] = {1'b0, ir[30], 5'd0};
                end
            end
            4, 5, 6, 7: begin
                ir[6:0]   = OP;
                ir[31:25] = {1'b0, ir[30], 5'd0};
            end
            8:  ir[6:0] = LUI;
            9:  ir[6:0] = AUIPC;
            10: ir[6:0] = JAL;
            11: begin
                ir[6:0]   = JALR;
                ir[14:12] = 3'd0;
            end
            12: ir[6:0] = BRANCH;
            13: ir[6:0] = LOAD;
            14: begin
                ir[6:0] = STORE;
                ir[14]  = 1'b0;
            end
            default: ir[6:0] = ir[0] ? 7'b0001111 : 7'b1110011;
        endcase
        return ir;
    endfunction

    initial begin
        down = 1'b0;
        forever #(PERIOD / 2) down = ~down;
    end

    initial begin
        arst_n     = 1'b0;
        inst_valid = 1'b0;
        inst_pc    = '0;
        inst_ir    = '0;
        res_ready  = 1'b0;
        repeat (2) @(posedge down);
        arst_n <= 1'b1;
    end

    initial begin : stimulus
        word_t pc;
        int    sent;
        pc   = 32'h0000_1000;
        sent = 0;
        wait (arst_n);
        forever begin
            @(posedge down);
            if (inst_valid && inst_ready) begin
                issued.push_back({inst_pc, inst_ir});
                sent++;
            end
            // New instruction only once the previous one is taken
            if (!inst_valid || inst_ready) begin
                if (sent < NUM_INST && ($random(seed) % 8) != 0) begin
                    inst_valid <= 1'b1;
                    inst_pc    <= pc;
                    inst_ir    <= make_inst();
                    pc = pc + 32'd4;
                end else begin
                    inst_valid <= 1'b0;
                end
            end
            res_ready <= ($random(seed) % 4) != 0;
        end
    end

    initial begin : scoreboard
        id_t   item;
        wb_t   exp;
        int    checked;
        logic  dec_valid;
        word_t dec_ir;
        checked   = 0;
        dec_valid = 1'b0;
        dec_ir    = '0;
        foreach (shadow[i]) begin
            shadow[i] = '0;
        end
        wait (arst_n);
        if (res_valid || illegal) begin
            abort_run("Result valid or illegal flag active right after reset");
        end
        while (checked < NUM_INST) begin
            @(posedge down);
            if (dut.u_props.failures != 0) begin
                abort_run("A stream handshake or x0 assertion failed");
            end
            // Decode holds what was taken on the last advancing edge
            check_word("illegal", word_t'(illegal), word_t'(dec_valid && !decodable(dec_ir)));
            if (inst_ready) begin
                dec_valid = inst_valid;
                dec_ir    = inst_ir;
            end
            if (res_valid && res_ready) begin
                if (issued.size() == 0) begin
                    abort_run("A result arrived with no instruction outstanding");
                end
                item = issued.pop_front();
                exp  = reference(shadow, item.pc, item.ir);
                check_op("res_op", res_op, exp.op);
                check_addr("res_rd", res_rd, exp.rd);
                check_word("res_value", res_value, exp.result);
                check_word("res_store", res_store, exp.store);
                check_word("res_taken", word_t'(res_taken), word_t'(exp.taken));
                check_word("res_target", res_target, exp.target);
                if (exp.op == REGISTER && exp.rd != '0) begin
                    shadow[exp.rd] = exp.result;
                end
                checked++;
            end
        end
        if (issued.size() == 0 && dut.u_props.failures == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // 40 cycles per instruction plus reset
    initial begin : watchdog
        #((NUM_INST * 40 + 10) * PERIOD);
        abort_run("Watchdog expired before all results arrived");
    end

endmodule

// ==== filelist.f ====
isa_pkg.sv
core_pkg.sv
pipe_reg.sv
regfile.sv
decode.sv
execute.sv
hazard_ctrl.sv
rv_core_top.sv
rv_core_properties.sv
tb_rv_core.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - isa_pkg.sv
  - core_pkg.sv
  - pipe_reg.sv
  - regfile.sv
  - decode.sv
  - execute.sv
  - hazard_ctrl.sv
  - rv_core_top.sv
  - target: test
    files:
      - rv_core_properties.sv
      - tb_rv_core.sv
